// ==== elevator_request_controller.f ====
elevator_pkg.sv
request_latch.sv
request_fifo.sv
car_dispatcher.sv
elevator_request_controller.sv
elevator_request_controller_assertions.sv
tb_elevator_request_controller.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, then searches the log for the pass message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_elevator_request_controller \
    -f elevator_request_controller.f -o tb_sim \
    && ./obj_dir/tb_sim +verilator+error+limit+1000 | tee sim.log \
    || echo "Build or simulation did not complete"

grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== tb_elevator_request_controller.sv ====
// Testbench for the elevator request controller
// Clock, reset and a model of the car FSM
// Capture, order, arrival, back-pressure, power, emergency and door tests
// One result line per test and a closing summary

`timescale 1ns/100ps

module tb_elevator_request_controller import elevator_pkg::*; ();

    logic        clock;
    logic        reset_n;
    floor_mask_t panel_buttons;
    floor_mask_t call_buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency;
    logic        power;
    car_status_t car_status;
    floor_mask_t panel_lights;
    floor_mask_t call_lights;
    dispatch_t   dispatch;
    logic        activate;
    logic        door_open_allowed;
    logic        door_close_allowed;

    integer      seed = 32'he333_57bf;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    // Freezes the car while it moves
    logic        car_hold;
    int          step_count;

    elevator_request_controller elevator_request_controller_inst (
        .clock             (clock),
        .reset_n           (reset_n),
        .panel_buttons     (panel_buttons),
        .call_buttons      (call_buttons),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .emergency         (emergency),
        .power             (power),
        .car_status        (car_status),
        .panel_lights      (panel_lights),
        .call_lights       (call_lights),
        .dispatch          (dispatch),
        .activate          (activate),
        .door_open_allowed (door_open_allowed),
        .door_close_allowed(door_close_allowed)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    //////////////////////////////////////////////////
    // Car model moving one floor every 4 cycles
    //////////////////////////////////////////////////

    always begin
        @(posedge clock);
        #1;
        if (!reset_n || !activate || car_status.floor == dispatch.target) begin
            car_status.moving = 1'b0;
            step_count = 0;
        end else if (!car_hold) begin
            car_status.moving = 1'b1;
            step_count++;
            if (step_count == 4) begin
                step_count = 0;
                if (dispatch.target > car_status.floor) begin
                    car_status.floor = car_status.floor + 4'd1;
                end else begin
                    car_status.floor = car_status.floor - 4'd1;
                end
                if (car_status.floor == dispatch.target) begin
                    car_status.moving = 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Next drive point
    // Buttons are let go once their light is on
    task automatic tick();
        @(posedge clock);
        #1;
        panel_buttons = panel_buttons & ~panel_lights;
        call_buttons  = call_buttons & ~call_lights;
    endtask

    task automatic check(input logic ok, input string msg);
        if (!ok) begin
            errors++;
            $display("Error at %0t ns: %s", $time, msg);
        end
    endtask

    function automatic int total_errors();
        return errors + elevator_request_controller_inst.assertions_inst.fail_count;
    endfunction

    task automatic wait_activate(input logic level, input int limit);
        int n;
        n = 0;
        while (activate !== level && n < limit) begin
            tick();
            n++;
        end
        if (activate !== level) begin
            errors++;
            $display("Timed out after %0d cycles waiting for activate to become %0b",
                     limit, level);
        end
    endtask

    // Holds a panel button until its light comes on or the limit runs out
    task automatic press_panel(input floor_t f, input int limit, output logic lit);
        int n;
        n = 0;
        panel_buttons[f] = 1'b1;
        tick();
        while (!panel_lights[f] && n < limit) begin
            tick();
            n++;
        end
        lit = panel_lights[f];
    endtask

    // Random floor outside the excluded set
    function automatic floor_t random_floor(input floor_mask_t exclude);
        int     start;
        floor_t f;
        start = $unsigned($random(seed)) % num_floors;
        f = floor_t'(start);
        for (int k = 0; k < num_floors; k++) begin
            f = floor_t'((start + k) % num_floors);
            if (!exclude[f]) begin
                return f;
            end
        end
        return f;
    endfunction

    task automatic finish_test(input string name, input int errors_before);
        if (total_errors() == errors_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed", name);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        floor_t      cur;
        floor_t      target;
        floor_t      f;
        floor_t      order [$];
        floor_mask_t used;
        logic        lit;
        int          base;
        int          lit_count;
        int          n;

        reset_n           = 1'b0;
        panel_buttons     = '0;
        call_buttons      = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power             = 1'b1;
        car_status        = '0;
        car_hold          = 1'b0;
        step_count        = 0;
        repeat (10) @(posedge clock);
        #1;
        reset_n = 1'b1;
        tick();

        // Capture
        base = total_errors();
        cur = car_status.floor;
        panel_buttons[cur] = 1'b1;
        repeat (6) begin
            tick();
            check(!panel_lights[cur], "press of the current floor lit its button");
        end
        panel_buttons[cur] = 1'b0;
        target = random_floor(floor_mask_t'(1) << cur);
        press_panel(target, 10, lit);
        check(lit, "held panel press was not lit");
        wait_activate(1'b1, 20);
        wait_activate(1'b0, 200);
        finish_test("capture", base);

        // Order and direction with the car held at its floor while requests queue up
        base = total_errors();
        used = floor_mask_t'(1) << car_status.floor;
        order.delete();
        car_hold = 1'b1;
        repeat (3) begin
            f = random_floor(used);
            used[f] = 1'b1;
            order.push_back(f);
            press_panel(f, 10, lit);
            check(lit, "press in a sequence was not lit");
        end
        for (int i = 0; i < order.size(); i++) begin
            wait_activate(1'b1, 200);
            check(dispatch.target == order[i], "trip started out of press order");
            check(dispatch.up == (dispatch.target > car_status.floor),
                  "direction does not match target and floor");
            car_hold = 1'b0;
            wait_activate(1'b0, 200);
        end
        finish_test("order", base);

        // Arrival with a call and a panel press of one floor
        base = total_errors();
        f = random_floor(floor_mask_t'(1) << car_status.floor);
        panel_buttons[f] = 1'b1;
        call_buttons[f] = 1'b1;
        n = 0;
        while (!(panel_lights[f] && call_lights[f]) && n < 10) begin
            tick();
            n++;
        end
        if (!(panel_lights[f] && call_lights[f])) begin
            errors++;
            $display("Timed out waiting for panel and call lights of one floor");
        end
        wait_activate(1'b1, 20);
        check(dispatch.target == f, "trip target is not the pressed floor");
        wait_activate(1'b0, 200);
        tick();
        tick();
        check(!panel_lights[f] && !call_lights[f], "lights still on after arrival");
        repeat (30) begin
            tick();
            check(!activate, "second trip for an already served floor");
        end
        finish_test("arrival", base);

        // Back-pressure with the car frozen mid-trip
        base = total_errors();
        target = random_floor(floor_mask_t'(1) << car_status.floor);
        press_panel(target, 10, lit);
        wait_activate(1'b1, 20);
        tick();
        car_hold = 1'b1;
        used = floor_mask_t'(1) << target;
        order.delete();
        lit_count = 0;
        repeat (num_floors - 1) begin
            f = random_floor(used);
            used[f] = 1'b1;
            order.push_back(f);
            press_panel(f, 12, lit);
            if (lit) begin
                lit_count++;
            end
        end
        check(lit_count <= queue_depth, "more presses lit than the queue holds");
        check($countones(panel_lights & ~(floor_mask_t'(1) << target)) <= queue_depth,
              "more panel lights on than the queue holds");
        car_hold = 1'b0;
        wait_activate(1'b0, 200);
        foreach (order[i]) begin
            wait_activate(1'b1, 200);
            check(dispatch.target == order[i], "queued floor served out of order");
            wait_activate(1'b0, 200);
        end
        check(panel_buttons == '0, "held press never accepted after the queue drained");
        panel_buttons = '0;
        finish_test("back_pressure", base);

        // Power loss and emergency
        base = total_errors();
        car_hold = 1'b1;
        target = random_floor(floor_mask_t'(1) << car_status.floor);
        press_panel(target, 10, lit);
        wait_activate(1'b1, 20);
        used = (floor_mask_t'(1) << car_status.floor) | (floor_mask_t'(1) << target);
        press_panel(random_floor(used), 10, lit);
        power = 1'b0;
        tick();
        check(!activate, "activate high after power loss");
        check(panel_lights == '0 && call_lights == '0, "lights on after power loss");
        tick();
        car_hold = 1'b0;
        power = 1'b1;
        repeat (40) begin
            tick();
            check(!activate, "trip started after power returned without a press");
        end
        // Emergency in the middle of a trip
        target = random_floor(floor_mask_t'(1) << car_status.floor);
        press_panel(target, 10, lit);
        wait_activate(1'b1, 20);
        tick();
        emergency = 1'b1;
        used = (floor_mask_t'(1) << car_status.floor) | (floor_mask_t'(1) << target);
        f = random_floor(used);
        panel_buttons[f] = 1'b1;
        call_buttons[f] = 1'b1;
        repeat (20) begin
            tick();
            check(!panel_lights[f] && !call_lights[f], "press lit during emergency");
            check(!activate, "activate high during emergency");
        end
        panel_buttons = '0;
        call_buttons = '0;
        emergency = 1'b0;
        // The held target resumes once the emergency ends
        wait_activate(1'b1, 20);
        check(dispatch.target == target, "trip after emergency lost its target");
        wait_activate(1'b0, 200);
        tick();
        finish_test("power_emergency", base);

        // Doors while stopped, then while moving
        base = total_errors();
        door_open_button = 1'b1;
        tick();
        check(door_open_allowed && !door_close_allowed, "open permission did not follow");
        door_open_button = 1'b0;
        door_close_button = 1'b1;
        tick();
        check(!door_open_allowed && door_close_allowed, "close permission did not follow");
        door_close_button = 1'b0;
        tick();
        check(!door_open_allowed && !door_close_allowed, "door permission stuck high");
        target = random_floor(floor_mask_t'(1) << car_status.floor);
        press_panel(target, 10, lit);
        wait_activate(1'b1, 20);
        tick();
        car_hold = 1'b1;
        door_open_button = 1'b1;
        door_close_button = 1'b1;
        repeat (6) begin
            tick();
            check(!door_open_allowed && !door_close_allowed, "door permission while moving");
        end
        door_open_button = 1'b0;
        door_close_button = 1'b0;
        car_hold = 1'b0;
        wait_activate(1'b0, 200);
        finish_test("doors", base);

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== elevator_request_controller_assertions.sv ====
// Concurrent invariant checks for the elevator request controller
// Power loss, door permission, trip direction and emergency
// Light clearing after arrival and push hold while the queue is full
// Attached to the top level with bind

`timescale 1ns/100ps

module elevator_request_controller_assertions import elevator_pkg::*; (
    input logic        clock,
    input logic        reset_n,
    input logic        power,
    input logic        emergency,
    input car_status_t car_status,
    input dispatch_t   dispatch,
    input logic        activate,
    input logic        arrival,
    input logic        push_valid,
    input logic        push_ready,
    input floor_t      push_floor,
    input floor_mask_t panel_lights,
    input floor_mask_t call_lights,
    input logic        door_open_allowed,
    input logic        door_close_allowed
);

    // Number of failed assertions
    int fail_count = 0;

    //////////////////////////////////////////////////
    // Trip control
    //////////////////////////////////////////////////

    power_off_stops_trip: assert property (@(posedge clock) disable iff (!reset_n)
        !power |=> !activate)
    else begin
        $error("activate still high in the cycle after power loss");
        fail_count++;
    end

    emergency_stops_trip: assert property (@(posedge clock) disable iff (!reset_n)
        emergency |=> !activate)
    else begin
        $error("activate high while emergency is active");
        fail_count++;
    end

    // Direction is judged against the floor where the trip starts
    up_matches_target: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(activate) |-> (dispatch.up == (dispatch.target > car_status.floor)))
    else begin
        $error("dispatch.up disagrees with target and floor at trip start");
        fail_count++;
    end

    //////////////////////////////////////////////////
    // Lights, doors and queue handshake
    //////////////////////////////////////////////////

    arrival_clears_lights: assert property (@(posedge clock) disable iff (!reset_n)
        arrival |=> !panel_lights[$past(car_status.floor)]
                    && !call_lights[$past(car_status.floor)])
    else begin
        $error("lights of the arrival floor still on after arrival");
        fail_count++;
    end

    doors_closed_while_moving: assert property (@(posedge clock) disable iff (!reset_n)
        car_status.moving |=> !door_open_allowed && !door_close_allowed)
    else begin
        $error("door permission high while the car is moving");
        fail_count++;
    end

    // A refused push keeps offering the same floor
    push_held_when_full: assert property (@(posedge clock) disable iff (!reset_n)
        push_valid && !push_ready && power |=> push_valid && $stable(push_floor))
    else begin
        $error("push request changed while the queue was full");
        fail_count++;
    end

endmodule

bind elevator_request_controller elevator_request_controller_assertions assertions_inst (
    .clock             (clock),
    .reset_n           (reset_n),
    .power             (power),
    .emergency         (emergency),
    .car_status        (car_status),
    .dispatch          (dispatch),
    .activate          (activate),
    .arrival           (arrival),
    .push_valid        (push_valid),
    .push_ready        (push_ready),
    .push_floor        (push_floor),
    .panel_lights      (panel_lights),
    .call_lights       (call_lights),
    .door_open_allowed (door_open_allowed),
    .door_close_allowed(door_close_allowed)
);

// ==== elevator_request_controller.sv ====
// Floor request controller for an eleven-floor elevator
// Button latch, request queue and car dispatcher
// Talks to an external car FSM through car_status and dispatch

`timescale 1ns/100ps

module elevator_request_controller import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t panel_buttons,
    input  floor_mask_t call_buttons,
    input  logic        door_open_button,
    input  logic        door_close_button,
    input  logic        emergency,
    input  logic        power,
    input  car_status_t car_status,
    output floor_mask_t panel_lights,
    output floor_mask_t call_lights,
    output dispatch_t   dispatch,
    output logic        activate,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    // Latch to queue
    logic   push_valid;
    logic   push_ready;
    floor_t push_floor;
    // Queue to dispatcher
    logic   pop_valid;
    logic   pop_ready;
    floor_t pop_floor;
    logic   arrival;
    logic   flush;

    // Power loss empties the queue
    assign flush = !power;

    request_latch request_latch_inst (
        .clock        (clock),
        .reset_n      (reset_n),
        .panel_buttons(panel_buttons),
        .call_buttons (call_buttons),
        .car_status   (car_status),
        .power        (power),
        .emergency    (emergency),
        .arrival      (arrival),
        .push_ready   (push_ready),
        .push_valid   (push_valid),
        .push_floor   (push_floor),
        .panel_lights (panel_lights),
        .call_lights  (call_lights)
    );

    request_fifo #(
        .depth(queue_depth)
    ) request_fifo_inst (
        .clock     (clock),
        .reset_n   (reset_n),
        .flush     (flush),
        .push_valid(push_valid),
        .push_floor(push_floor),
        .push_ready(push_ready),
        .pop_valid (pop_valid),
        .pop_floor (pop_floor),
        .pop_ready (pop_ready)
    );

    car_dispatcher car_dispatcher_inst (
        .clock             (clock),
        .reset_n           (reset_n),
        .car_status        (car_status),
        .power             (power),
        .emergency         (emergency),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .pop_valid         (pop_valid),
        .pop_floor         (pop_floor),
        .pop_ready         (pop_ready),
        .dispatch          (dispatch),
        .activate          (activate),
        .arrival           (arrival),
        .door_open_allowed (door_open_allowed),
        .door_close_allowed(door_close_allowed)
    );

endmodule

// ==== car_dispatcher.sv ====
// Trip control for the elevator request controller
// Pops the oldest request and holds it as the car target
// Arrival detection and direction
// Registered door permissions

`timescale 1ns/100ps

module car_dispatcher import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  car_status_t car_status,
    input  logic        power,
    input  logic        emergency,
    input  logic        door_open_button,
    input  logic        door_close_button,
    input  logic        pop_valid,
    input  floor_t      pop_floor,
    output logic        pop_ready,
    output dispatch_t   dispatch,
    output logic        activate,
    output logic        arrival,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    // A target is held from pop until arrival
    logic have_target;
    logic stopped;
    logic start_trip;
    logic resume_trip;
    logic at_target;

    assign stopped     = !car_status.moving;
    assign pop_ready   = power && !emergency && stopped && !have_target;
    assign start_trip  = pop_valid && pop_ready;
    // Only an emergency leaves a held target without activate
    assign resume_trip = power && !emergency && stopped && have_target && !activate;
    assign at_target   = activate && stopped && (car_status.floor == dispatch.target);

    //////////////////////////////////////////////////
    // Trip state
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            have_target <= 1'b0;
            activate    <= 1'b0;
            arrival     <= 1'b0;
        end else begin
            arrival <= 1'b0;
            if (!power) begin
                // Power loss drops the trip
                have_target <= 1'b0;
                activate    <= 1'b0;
            end else if (emergency) begin
                activate <= 1'b0;
            end else if (at_target) begin
                have_target <= 1'b0;
                activate    <= 1'b0;
                arrival     <= 1'b1;
            end else if (start_trip) begin
                have_target <= 1'b1;
                activate    <= 1'b1;
            end else if (resume_trip) begin
                activate <= 1'b1;
            end
        end
    end

    // Target and direction
    always_ff @(posedge clock) begin
        if (start_trip) begin
            dispatch.target <= pop_floor;
            dispatch.up     <= (pop_floor > car_status.floor);
        end else if (resume_trip) begin
            // Car may have stopped short of the target
            dispatch.up <= (dispatch.target > car_status.floor);
        end
    end

    //////////////////////////////////////////////////
    // Door permission
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else if (power && stopped) begin
            door_open_allowed  <= door_open_button;
            door_close_allowed <= door_close_button;
        end else begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end
    end

endmodule

// ==== request_fifo.sv ====
// Ordered request queue for the elevator request controller
// Circular buffer with read and write pointers and a count
// Valid/ready on both sides, flush empties the queue

`timescale 1ns/100ps

module request_fifo import elevator_pkg::*; #(
    parameter int depth = queue_depth
) (
    input  logic   clock,
    input  logic   reset_n,
    input  logic   flush,
    input  logic   push_valid,
    input  floor_t push_floor,
    output logic   push_ready,
    output logic   pop_valid,
    output floor_t pop_floor,
    input  logic   pop_ready
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    floor_t           mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointer advance with wrap at the last entry
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ready = (count != cnt_w'(depth));
    assign pop_valid  = (count != '0);
    assign pop_floor  = mem[rd_ptr];
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    //////////////////////////////////////////////////
    // Pointers and fill level
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop keep the count
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_floor;
        end
    end

endmodule

// ==== request_latch.sv ====
// Button capture for the elevator request controller
// Panel and hall call lights
// Duplicate filtering per floor
// Push side of the request queue handshake

`timescale 1ns/100ps

module request_latch import elevator_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t panel_buttons,
    input  floor_mask_t call_buttons,
    input  car_status_t car_status,
    input  logic        power,
    input  logic        emergency,
    input  logic        arrival,
    input  logic        push_ready,
    output logic        push_valid,
    output floor_t      push_floor,
    output floor_mask_t panel_lights,
    output floor_mask_t call_lights
);

    // Source of the pending push
    logic        pend_call;

    floor_mask_t floor_lit;
    floor_mask_t here_mask;
    floor_mask_t pend_mask;
    floor_mask_t allowed;
    floor_mask_t need_mask;
    floor_mask_t panel_new;
    floor_mask_t call_new;
    floor_mask_t pick_mask;
    logic        pick_call;
    logic        pick_found;
    logic        pick_direct;
    floor_t      pick_floor;

    // Lowest set bit of a floor mask
    function automatic floor_t lowest_floor(input floor_mask_t mask);
        floor_t result;
        result = '0;
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (mask[i]) begin
                result = floor_t'(i);
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////
    // Press selection
    //////////////////////////////////////////////////

    always_comb begin
        floor_lit = panel_lights | call_lights;
        // The current floor is not a request while the car stands there
        here_mask = car_status.moving ? '0 : floor_mask_t'(1) << car_status.floor;
        // Presses of the floor in flight wait until it is accepted
        pend_mask = push_valid ? floor_mask_t'(1) << push_floor : '0;
        allowed   = (power && !emergency) ? ~(here_mask | pend_mask) : '0;
        // A busy push port leaves only presses that need no push
        need_mask = push_valid ? floor_lit : '1;
        panel_new = panel_buttons & ~panel_lights & allowed & need_mask;
        call_new  = call_buttons & ~call_lights & allowed & need_mask;

        // Panel presses win over hall calls
        pick_call   = (panel_new == '0);
        pick_mask   = pick_call ? call_new : panel_new;
        pick_found  = |pick_mask;
        pick_floor  = lowest_floor(pick_mask);
        pick_direct = floor_lit[pick_floor];
    end

    //////////////////////////////////////////////////
    // Lights and push control
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            push_valid   <= 1'b0;
            panel_lights <= '0;
            call_lights  <= '0;
        end else if (!power) begin
            push_valid   <= 1'b0;
            panel_lights <= '0;
            call_lights  <= '0;
        end else begin
            // Light comes on with the accepted push
            if (push_valid && push_ready) begin
                push_valid <= 1'b0;
                if (pend_call) begin
                    call_lights[push_floor] <= 1'b1;
                end else begin
                    panel_lights[push_floor] <= 1'b1;
                end
            end
            if (pick_found) begin
                if (pick_direct) begin
                    // Floor already queued
                    if (pick_call) begin
                        call_lights[pick_floor] <= 1'b1;
                    end else begin
                        panel_lights[pick_floor] <= 1'b1;
                    end
                end else begin
                    push_valid <= 1'b1;
                end
            end
            if (arrival) begin
                panel_lights[car_status.floor] <= 1'b0;
                call_lights[car_status.floor]  <= 1'b0;
            end
        end
    end

    // Floor offered to the queue
    always_ff @(posedge clock) begin
        if (pick_found && !pick_direct && !push_valid) begin
            push_floor <= pick_floor;
            pend_call  <= pick_call;
        end
    end

endmodule

// ==== elevator_pkg.sv ====
// Shared definitions for the elevator request controller
// Floor count and request queue depth
// Floor index and per-floor mask types
// Car status and dispatch command structs

package elevator_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Floors served by the car
    // Index 0 is the first floor and index 10 the eleventh
    localparam int num_floors = 11;

    // Requests held in the queue
    // Kept below the floor count so the queue can fill up
    localparam int queue_depth = 8;

    // Bits of a floor index
    localparam int floor_w = 4;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    // Floor index
    typedef logic [floor_w-1:0] floor_t;

    // One bit per floor for buttons and lights
    typedef logic [num_floors-1:0] floor_mask_t;

    // Status reported by the car FSM
    typedef struct packed {
        floor_t floor;
        logic   moving;
    } car_status_t;

    // Command to the car FSM
    typedef struct packed {
        floor_t target;
        // High when the target lies above the floor at trip start
        logic   up;
    } dispatch_t;

endpackage
